/* flist.f */
source/wb_pkg.sv
source/soc_pkg.sv
source/wb_arbiter.sv
source/boot_mem.sv
source/timer_module.sv
source/interrupt_controller.sv
source/amber_system.sv
dv/system_asserts.sv
dv/tb_system.sv

/* Makefile */
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_system \
		-Mdir $(BUILD_DIR) -o Vtb_system -f flist.f

run: compile
	./$(BUILD_DIR)/Vtb_system > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Simulation PASSED" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_system.sv */
// Subsystem testbench
`timescale 1ns/1ps

module tb_system;

    localparam int     CLK_PERIOD   = 100;
    localparam int     DRIVE_DLY    = 10;
    localparam int     RST_CYCLES   = 5;
    localparam int     BUS_TIMEOUT  = 16;
    localparam int     NUM_MEM_OPS  = 16;
    localparam int     MAX_POLLS    = 16;
    // Access count of all tests, each access well under 8 cycles
    localparam int     MAX_ACCESSES = 3 * NUM_MEM_OPS + MAX_POLLS + 40;
    localparam longint WATCHDOG_NS  = 2 * (RST_CYCLES + 8 * MAX_ACCESSES) * CLK_PERIOD;

    logic            clk = 1'b0;
    logic            rst;
    wb_pkg::wb_req_t m0_req;
    wb_pkg::wb_rsp_t m0_rsp;
    wb_pkg::wb_req_t m1_req;
    wb_pkg::wb_rsp_t m1_rsp;
    logic            irq;
    logic            firq;

    logic [wb_pkg::WB_DWIDTH-1:0] mem_model [soc_pkg::BOOT_WORDS];
    int data_errors  = 0;
    int rsp_errors   = 0;
    int irq_errors   = 0;
    int other_errors = 0;

    amber_system u_dut (
        .i_clk    ( clk    ),
        .i_rst    ( rst    ),
        .i_m0_req ( m0_req ),
        .o_m0_rsp ( m0_rsp ),
        .i_m1_req ( m1_req ),
        .o_m1_rsp ( m1_rsp ),
        .o_irq    ( irq    ),
        .o_firq   ( firq   )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // Address helpers and checks
    // ------------------------------------------------------------------------

    function automatic logic [31:0] boot_adr(input int idx);
        return {wb_pkg::BOOT_BASE, 14'h0, idx[7:0], 2'b00};
    endfunction

    function automatic logic [31:0] timer_adr(input int t, input soc_pkg::timer_reg_e r);
        return {wb_pkg::TIMER_BASE, 14'h0, t[1:0], 4'h0, r, 2'b00};
    endfunction

    function automatic logic [31:0] ic_adr(input soc_pkg::ic_reg_e r);
        return {wb_pkg::IC_BASE, 18'h0, r, 2'b00};
    endfunction

    function automatic wb_pkg::wb_rsp_t make_rsp(input logic ack, input logic err);
        wb_pkg::wb_rsp_t rsp;
        rsp     = '0;
        rsp.ack = ack;
        rsp.err = err;
        return rsp;
    endfunction

    // Only the selected byte lanes change
    function automatic void update_model(input int idx, input logic [3:0] sel,
                                         input logic [31:0] dat);
        for (int b = 0; b < wb_pkg::WB_SWIDTH; b++) begin
            if (sel[b]) begin
                mem_model[idx][b*8 +: 8] = dat[b*8 +: 8];
            end
        end
    endfunction

    task automatic compare_data(input logic [wb_pkg::WB_DWIDTH-1:0] got,
                                input logic [wb_pkg::WB_DWIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0d ns: %s read %h, expected %h", $time, what, got, exp);
            data_errors++;
        end
    endtask

    task automatic compare_rsp(input wb_pkg::wb_rsp_t got, input wb_pkg::wb_rsp_t exp,
                               input string what);
        if (got.ack !== exp.ack || got.err !== exp.err) begin
            $display("error at %0d ns: %s ack/err %b/%b, expected %b/%b",
                     $time, what, got.ack, got.err, exp.ack, exp.err);
            rsp_errors++;
        end
    endtask

    task automatic compare_irq(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            irq_errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus access
    // ------------------------------------------------------------------------

    task automatic put_request(input int master, input wb_pkg::wb_req_t req);
        if (master == 0) begin
            m0_req = req;
        end else begin
            m1_req = req;
        end
    endtask

    // Holds the request until ack or err, then drops cyc and stb
    task automatic do_access(input int master, input logic we, input logic [31:0] adr,
                             input logic [3:0] sel, input logic [31:0] wdat,
                             output wb_pkg::wb_rsp_t rsp, output time ack_time);
        wb_pkg::wb_req_t req;
        wb_pkg::wb_rsp_t cur;
        int              waited;
        req     = '0;
        req.adr = adr;
        req.sel = sel;
        req.we  = we;
        req.dat = wdat;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        rsp      = '0;
        ack_time = 0;
        waited   = 0;
        @(posedge clk);
        #DRIVE_DLY;
        put_request(master, req);
        do begin
            @(negedge clk);
            cur = (master == 0) ? m0_rsp : m1_rsp;
            waited++;
        end while (!cur.ack && !cur.err && waited < BUS_TIMEOUT);
        if (cur.ack || cur.err) begin
            rsp      = cur;
            ack_time = $time;
        end else begin
            $display("Bus timeout: master %0d got no ack or err for address %h", master, adr);
            other_errors++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        put_request(master, '0);
    endtask

    task automatic write_word(input int master, input logic [31:0] adr,
                              input logic [3:0] sel, input logic [31:0] dat);
        wb_pkg::wb_rsp_t rsp;
        time             t_ack;
        do_access(master, 1'b1, adr, sel, dat, rsp, t_ack);
        compare_rsp(rsp, make_rsp(1'b1, 1'b0), "write response");
    endtask

    task automatic read_word(input int master, input logic [31:0] adr,
                             output logic [31:0] dat);
        wb_pkg::wb_rsp_t rsp;
        time             t_ack;
        do_access(master, 1'b0, adr, 4'hF, 32'h0, rsp, t_ack);
        compare_rsp(rsp, make_rsp(1'b1, 1'b0), "read response");
        dat = rsp.dat;
    endtask

    task automatic expect_reg(input logic [31:0] adr, input logic [31:0] exp,
                              input string what);
        logic [31:0] got;
        read_word(0, adr, got);
        compare_data(got, exp, what);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic boot_mem_rw_test();
        int          idx_list [NUM_MEM_OPS];
        int          idx;
        logic [31:0] dat;
        logic [3:0]  sel;
        for (int i = 0; i < NUM_MEM_OPS; i++) begin
            idx_list[i] = int'($urandom % soc_pkg::BOOT_WORDS);
            dat = $urandom;
            write_word(i % 2, boot_adr(idx_list[i]), 4'hF, dat);
            update_model(idx_list[i], 4'hF, dat);
        end
        // Partial writes only hit words that hold known data
        for (int i = 0; i < NUM_MEM_OPS; i++) begin
            idx = idx_list[$urandom % NUM_MEM_OPS];
            sel = 4'($urandom % 15 + 1);
            dat = $urandom;
            write_word((i + 1) % 2, boot_adr(idx), sel, dat);
            update_model(idx, sel, dat);
        end
        for (int i = 0; i < NUM_MEM_OPS; i++) begin
            expect_reg(boot_adr(idx_list[i]), mem_model[idx_list[i]], "boot memory");
        end
    endtask

    task automatic unmapped_access_test();
        wb_pkg::wb_rsp_t rsp;
        time             t_ack;
        logic [31:0]     adr;
        logic [31:0]     dat;
        int              idx;
        adr = {8'h80 | 8'($urandom % 8'h70), 24'($urandom)};
        do_access(0, 1'b1, adr, 4'hF, $urandom, rsp, t_ack);
        compare_rsp(rsp, make_rsp(1'b0, 1'b1), "unmapped write");
        do_access(1, 1'b0, adr, 4'hF, 32'h0, rsp, t_ack);
        compare_rsp(rsp, make_rsp(1'b0, 1'b1), "unmapped read");
        idx = int'($urandom % soc_pkg::BOOT_WORDS);
        dat = $urandom;
        write_word(0, boot_adr(idx), 4'hF, dat);
        update_model(idx, 4'hF, dat);
        expect_reg(boot_adr(idx), mem_model[idx], "access after unmapped");
    endtask

    task automatic timer_reload_test();
        int          t;
        int          polls;
        logic [31:0] n;
        logic [31:0] val;
        logic [31:0] raw;
        logic        seen;
        t = int'($urandom % soc_pkg::NUM_TIMERS);
        n = 32'd8 + ($urandom % 8);
        write_word(1, timer_adr(t, soc_pkg::TMR_LOAD), 4'hF, n);
        write_word(1, timer_adr(t, soc_pkg::TMR_CTRL), 4'hF, 32'h1 << soc_pkg::TMR_CTRL_EN);
        seen  = 1'b0;
        polls = 0;
        while (!seen && polls < MAX_POLLS) begin
            read_word(1, ic_adr(soc_pkg::IC_IRQ_RAW), raw);
            seen = raw[soc_pkg::IRQ_SRC_TIMER0 + t];
            polls++;
        end
        if (!seen) begin
            $display("Timer %0d never raised its interrupt after %0d polls", t, polls);
            other_errors++;
        end
        read_word(1, timer_adr(t, soc_pkg::TMR_VALUE), val);
        if (val > n) begin
            $display("error at %0d ns: timer %0d value %0d above load %0d", $time, t, val, n);
            data_errors++;
        end
        write_word(1, timer_adr(t, soc_pkg::TMR_CTRL), 4'hF, 32'h0);
        write_word(1, timer_adr(t, soc_pkg::TMR_CLEAR), 4'hF, 32'h1);
        read_word(1, ic_adr(soc_pkg::IC_IRQ_RAW), raw);
        compare_irq(raw[soc_pkg::IRQ_SRC_TIMER0 + t], 1'b0, "timer raw bit after clear");
    endtask

    task automatic irq_routing_test();
        logic [3:0] raw_exp;
        logic [3:0] mask;
        raw_exp = 4'b0001 << soc_pkg::IRQ_SRC_SOFT;
        mask    = raw_exp;
        write_word(0, ic_adr(soc_pkg::IC_SOFT_SET), 4'hF, 32'h1);
        expect_reg(ic_adr(soc_pkg::IC_IRQ_RAW), 32'(raw_exp), "raw with soft bit");

        write_word(0, ic_adr(soc_pkg::IC_IRQ_EN_SET), 4'hF, 32'(mask));
        @(negedge clk);
        compare_irq(irq, |(raw_exp & mask), "o_irq after enable");
        compare_irq(firq, 1'b0, "o_firq with irq enable");
        expect_reg(ic_adr(soc_pkg::IC_IRQ_STATUS), 32'(raw_exp & mask), "irq status");
        write_word(0, ic_adr(soc_pkg::IC_IRQ_EN_CLR), 4'hF, 32'(mask));
        @(negedge clk);
        compare_irq(irq, 1'b0, "o_irq after enable clear");
        expect_reg(ic_adr(soc_pkg::IC_IRQ_STATUS), 32'h0, "irq status after clear");

        // Same sequence on the fast path
        write_word(0, ic_adr(soc_pkg::IC_FIRQ_EN_SET), 4'hF, 32'(mask));
        @(negedge clk);
        compare_irq(firq, |(raw_exp & mask), "o_firq after enable");
        compare_irq(irq, 1'b0, "o_irq with firq enable");
        expect_reg(ic_adr(soc_pkg::IC_FIRQ_STATUS), 32'(raw_exp & mask), "firq status");
        write_word(0, ic_adr(soc_pkg::IC_FIRQ_EN_CLR), 4'hF, 32'(mask));
        @(negedge clk);
        compare_irq(firq, 1'b0, "o_firq after enable clear");
        expect_reg(ic_adr(soc_pkg::IC_FIRQ_STATUS), 32'h0, "firq status after clear");

        write_word(0, ic_adr(soc_pkg::IC_SOFT_CLR), 4'hF, 32'h1);
        expect_reg(ic_adr(soc_pkg::IC_IRQ_RAW), 32'h0, "raw after soft clear");
    endtask

    task automatic contention_test();
        wb_pkg::wb_rsp_t r0;
        wb_pkg::wb_rsp_t r1;
        time             t0;
        time             t1;
        int              idx0;
        int              idx1;
        logic [31:0]     d0;
        logic [31:0]     d1;
        idx0 = int'($urandom % soc_pkg::BOOT_WORDS);
        idx1 = (idx0 + 1 + int'($urandom % (soc_pkg::BOOT_WORDS - 1))) % soc_pkg::BOOT_WORDS;
        d0 = $urandom;
        d1 = $urandom;
        fork
            do_access(0, 1'b1, boot_adr(idx0), 4'hF, d0, r0, t0);
            do_access(1, 1'b1, boot_adr(idx1), 4'hF, d1, r1, t1);
        join
        compare_rsp(r0, make_rsp(1'b1, 1'b0), "master 0 contended write");
        compare_rsp(r1, make_rsp(1'b1, 1'b0), "master 1 contended write");
        if (t0 >= t1) begin
            $display("Master 0 was not served first: ack at %0d ns, master 1 at %0d ns",
                     t0, t1);
            other_errors++;
        end
        update_model(idx0, 4'hF, d0);
        update_model(idx1, 4'hF, d1);
        expect_reg(boot_adr(idx0), mem_model[idx0], "master 0 word after contention");
        expect_reg(boot_adr(idx1), mem_model[idx1], "master 1 word after contention");
    endtask

    // Reset drops o_irq even while a source is still pending
    task automatic reset_clears_irq_test();
        write_word(0, ic_adr(soc_pkg::IC_SOFT_SET), 4'hF, 32'h1);
        write_word(0, ic_adr(soc_pkg::IC_IRQ_EN_SET), 4'hF,
                   32'h1 << soc_pkg::IRQ_SRC_SOFT);
        @(negedge clk);
        compare_irq(irq, 1'b1, "o_irq before reset");
        @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_irq(irq, 1'b0, "o_irq during reset");
        compare_irq(firq, 1'b0, "o_firq during reset");
        @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        expect_reg(ic_adr(soc_pkg::IC_IRQ_RAW), 32'h0, "raw after reset");
    endtask

    // ------------------------------------------------------------------------
    // Sequence, watchdog and report
    // ------------------------------------------------------------------------

    initial begin
        int total;
        void'($urandom(32'h5051));
        rst    = 1'b1;
        m0_req = '0;
        m1_req = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        compare_irq(irq, 1'b0, "o_irq after reset");
        compare_irq(firq, 1'b0, "o_firq after reset");

        boot_mem_rw_test();
        unmapped_access_test();
        timer_reload_test();
        irq_routing_test();
        contention_test();
        reset_clears_irq_test();

        repeat (2) @(posedge clk);
        total = data_errors + rsp_errors + irq_errors + other_errors;
        $display("Errors: data %0d, response %0d, irq %0d, other %0d, total %0d",
                 data_errors, rsp_errors, irq_errors, other_errors, total);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* dv/system_asserts.sv */
// Bus protocol assertions
`timescale 1ns/1ps

module system_asserts (
    input  logic             i_clk,
    input  logic             i_rst,
    input  wb_pkg::wb_req_t  i_m0_req,
    input  wb_pkg::wb_rsp_t  i_m0_rsp,
    input  wb_pkg::wb_req_t  i_m1_req,
    input  wb_pkg::wb_rsp_t  i_m1_rsp,
    input  logic             i_irq
);

    // A cycle ends with either ack or err, never both
    ack_err_m0: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_m0_rsp.ack && i_m0_rsp.err))
        else $error("master 0 sees ack and err together");

    ack_err_m1: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_m1_rsp.ack && i_m1_rsp.err))
        else $error("master 1 sees ack and err together");

    ack_cyc_m0: assert property (@(posedge i_clk) disable iff (i_rst)
        i_m0_rsp.ack |-> i_m0_req.cyc)
        else $error("master 0 sees ack without cyc");

    ack_cyc_m1: assert property (@(posedge i_clk) disable iff (i_rst)
        i_m1_rsp.ack |-> i_m1_req.cyc)
        else $error("master 1 sees ack without cyc");

    // Only the granted master gets an answer
    one_ack: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_m0_rsp.ack && i_m1_rsp.ack))
        else $error("both masters see ack in the same cycle");

    // Output is registered, so the first reset edge is skipped
    irq_in_reset: assert property (@(posedge i_clk)
        (i_rst && $past(i_rst)) |-> !i_irq)
        else $error("o_irq high during reset");

endmodule

bind amber_system system_asserts u_system_asserts (
    .i_clk    ( i_clk    ),
    .i_rst    ( i_rst    ),
    .i_m0_req ( i_m0_req ),
    .i_m0_rsp ( o_m0_rsp ),
    .i_m1_req ( i_m1_req ),
    .i_m1_rsp ( o_m1_rsp ),
    .i_irq    ( o_irq    )
);

/* source/amber_system.sv */
// Amber Wishbone subsystem
`timescale 1ns/1ps

module amber_system (
    input  logic             i_clk,
    input  logic             i_rst,
    input  wb_pkg::wb_req_t  i_m0_req,
    output wb_pkg::wb_rsp_t  o_m0_rsp,
    input  wb_pkg::wb_req_t  i_m1_req,
    output wb_pkg::wb_rsp_t  o_m1_rsp,
    output logic             o_irq,
    output logic             o_firq
);

    wb_pkg::wb_req_t                 slv_req;
    wb_pkg::slave_sel_e              slv_sel;
    wb_pkg::wb_rsp_t                 boot_rsp;
    wb_pkg::wb_rsp_t                 timer_rsp;
    wb_pkg::wb_rsp_t                 ic_rsp;
    logic [soc_pkg::NUM_TIMERS-1:0]  timer_int;

    // ------------------------------------------------------------------------
    // Bus fabric
    // ------------------------------------------------------------------------
    wb_arbiter u_wb_arbiter (
        .i_clk       ( i_clk      ),
        .i_rst       ( i_rst      ),
        .i_m0_req    ( i_m0_req   ),
        .o_m0_rsp    ( o_m0_rsp   ),
        .i_m1_req    ( i_m1_req   ),
        .o_m1_rsp    ( o_m1_rsp   ),
        .o_slv_req   ( slv_req    ),
        .o_slv_sel   ( slv_sel    ),
        .i_boot_rsp  ( boot_rsp   ),
        .i_timer_rsp ( timer_rsp  ),
        .i_ic_rsp    ( ic_rsp     )
    );

    // ------------------------------------------------------------------------
    // Slaves
    // ------------------------------------------------------------------------
    boot_mem u_boot_mem (
        .i_clk       ( i_clk      ),
        .i_rst       ( i_rst      ),
        .i_req       ( slv_req    ),
        .i_sel       ( slv_sel    ),
        .o_rsp       ( boot_rsp   )
    );

    timer_module u_timer_module (
        .i_clk       ( i_clk      ),
        .i_rst       ( i_rst      ),
        .i_req       ( slv_req    ),
        .i_sel       ( slv_sel    ),
        .o_rsp       ( timer_rsp  ),
        .o_timer_int ( timer_int  )
    );

    interrupt_controller u_interrupt_controller (
        .i_clk       ( i_clk      ),
        .i_rst       ( i_rst      ),
        .i_req       ( slv_req    ),
        .i_sel       ( slv_sel    ),
        .o_rsp       ( ic_rsp     ),
        .i_timer_int ( timer_int  ),
        .o_irq       ( o_irq      ),
        .o_firq      ( o_firq     )
    );

endmodule

/* source/interrupt_controller.sv */
// Interrupt controller
`timescale 1ns/1ps

module interrupt_controller (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  wb_pkg::wb_req_t                 i_req,
    input  wb_pkg::slave_sel_e              i_sel,
    output wb_pkg::wb_rsp_t                 o_rsp,
    input  logic [soc_pkg::NUM_TIMERS-1:0]  i_timer_int,
    output logic                            o_irq,
    output logic                            o_firq
);

    logic [soc_pkg::NUM_IRQ_SRC-1:0] raw;
    logic [soc_pkg::NUM_IRQ_SRC-1:0] irq_en_q;
    logic [soc_pkg::NUM_IRQ_SRC-1:0] firq_en_q;
    logic [soc_pkg::NUM_IRQ_SRC-1:0] wr_bits;
    logic                            soft_q;
    soc_pkg::ic_reg_e                reg_sel;
    logic                            access;
    logic                            ack_q;
    logic [wb_pkg::WB_DWIDTH-1:0]    rd_data;
    logic [wb_pkg::WB_DWIDTH-1:0]    rdata_q;

    // Soft bit at 0, timers above it
    always_comb begin
        raw = '0;
        raw[soc_pkg::IRQ_SRC_SOFT] = soft_q;
        raw[soc_pkg::IRQ_SRC_TIMER0 +: soc_pkg::NUM_TIMERS] = i_timer_int;
    end

    assign reg_sel = soc_pkg::ic_reg_e'(i_req.adr[5:2]);
    assign access  = i_req.cyc && i_req.stb && (i_sel == wb_pkg::SLV_IC) && !ack_q;
    assign wr_bits = i_req.dat[soc_pkg::NUM_IRQ_SRC-1:0];

    // ------------------------------------------------------------------------
    // Enable masks, soft bit and outputs
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            irq_en_q  <= '0;
            firq_en_q <= '0;
            soft_q    <= 1'b0;
            ack_q     <= 1'b0;
            o_irq     <= 1'b0;
            o_firq    <= 1'b0;
        end else begin
            ack_q  <= access;
            o_irq  <= |(raw & irq_en_q);
            o_firq <= |(raw & firq_en_q);
            if (access && i_req.we) begin
                case (reg_sel)
                    soc_pkg::IC_IRQ_EN_SET:  irq_en_q  <= irq_en_q | wr_bits;
                    soc_pkg::IC_IRQ_EN_CLR:  irq_en_q  <= irq_en_q & ~wr_bits;
                    soc_pkg::IC_FIRQ_EN_SET: firq_en_q <= firq_en_q | wr_bits;
                    soc_pkg::IC_FIRQ_EN_CLR: firq_en_q <= firq_en_q & ~wr_bits;
                    soc_pkg::IC_SOFT_SET:    if (i_req.dat[0]) soft_q <= 1'b1;
                    soc_pkg::IC_SOFT_CLR:    if (i_req.dat[0]) soft_q <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // Set registers read back the current mask
    always_comb begin
        rd_data = '0;
        case (reg_sel)
            soc_pkg::IC_IRQ_STATUS:  rd_data[soc_pkg::NUM_IRQ_SRC-1:0] = raw & irq_en_q;
            soc_pkg::IC_IRQ_RAW:     rd_data[soc_pkg::NUM_IRQ_SRC-1:0] = raw;
            soc_pkg::IC_IRQ_EN_SET:  rd_data[soc_pkg::NUM_IRQ_SRC-1:0] = irq_en_q;
            soc_pkg::IC_FIRQ_STATUS: rd_data[soc_pkg::NUM_IRQ_SRC-1:0] = raw & firq_en_q;
            soc_pkg::IC_FIRQ_EN_SET: rd_data[soc_pkg::NUM_IRQ_SRC-1:0] = firq_en_q;
            soc_pkg::IC_SOFT_SET:    rd_data[0] = soft_q;
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            rdata_q <= rd_data;
        end
    end

    assign o_rsp.dat = rdata_q;
    assign o_rsp.ack = ack_q;
    assign o_rsp.err = 1'b0;

endmodule

/* source/timer_module.sv */
// Three-channel down counter
`timescale 1ns/1ps

module timer_module (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  wb_pkg::wb_req_t                 i_req,
    input  wb_pkg::slave_sel_e              i_sel,
    output wb_pkg::wb_rsp_t                 o_rsp,
    output logic [soc_pkg::NUM_TIMERS-1:0]  o_timer_int
);

    logic [wb_pkg::WB_DWIDTH-1:0] load_q  [soc_pkg::NUM_TIMERS];
    logic [wb_pkg::WB_DWIDTH-1:0] value_q [soc_pkg::NUM_TIMERS];
    logic [soc_pkg::NUM_TIMERS-1:0] en_q;
    logic [soc_pkg::NUM_TIMERS-1:0] flag_q;
    logic [soc_pkg::NUM_TIMERS-1:0] fire;
    logic [1:0]                   tmr_idx;
    soc_pkg::timer_reg_e          reg_sel;
    logic                         access;
    logic                         ack_q;
    logic [wb_pkg::WB_DWIDTH-1:0] rd_data;
    logic [wb_pkg::WB_DWIDTH-1:0] rdata_q;

    assign tmr_idx = i_req.adr[9:8];
    assign reg_sel = soc_pkg::timer_reg_e'(i_req.adr[3:2]);
    assign access  = i_req.cyc && i_req.stb && (i_sel == wb_pkg::SLV_TIMER) && !ack_q;

    // Reload when the count would pass from 1 to 0
    always_comb begin
        for (int t = 0; t < soc_pkg::NUM_TIMERS; t++) begin
            fire[t] = en_q[t] && (value_q[t] <= 1);
        end
    end

    // ------------------------------------------------------------------------
    // Counters and register writes
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            en_q   <= '0;
            flag_q <= '0;
            ack_q  <= 1'b0;
            for (int t = 0; t < soc_pkg::NUM_TIMERS; t++) begin
                load_q[t]  <= '0;
                value_q[t] <= '0;
            end
        end else begin
            ack_q <= access;
            for (int t = 0; t < soc_pkg::NUM_TIMERS; t++) begin
                if (fire[t]) begin
                    flag_q[t]  <= 1'b1;
                    value_q[t] <= load_q[t];
                end else if (en_q[t]) begin
                    value_q[t] <= value_q[t] - 1'b1;
                end
                if (access && i_req.we && (tmr_idx == 2'(t))) begin
                    case (reg_sel)
                        soc_pkg::TMR_LOAD: begin
                            load_q[t]  <= i_req.dat;
                            value_q[t] <= i_req.dat;
                        end
                        soc_pkg::TMR_CTRL:  en_q[t] <= i_req.dat[soc_pkg::TMR_CTRL_EN];
                        // A new event in the same cycle is kept
                        soc_pkg::TMR_CLEAR: if (!fire[t]) flag_q[t] <= 1'b0;
                        default: ;
                    endcase
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read data
    // ------------------------------------------------------------------------

    always_comb begin
        rd_data = '0;
        if (tmr_idx < soc_pkg::NUM_TIMERS) begin
            case (reg_sel)
                soc_pkg::TMR_LOAD:  rd_data = load_q[tmr_idx];
                soc_pkg::TMR_VALUE: rd_data = value_q[tmr_idx];
                soc_pkg::TMR_CTRL:  rd_data[soc_pkg::TMR_CTRL_EN] = en_q[tmr_idx];
                soc_pkg::TMR_CLEAR: rd_data[0] = flag_q[tmr_idx];
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            rdata_q <= rd_data;
        end
    end

    assign o_rsp.dat   = rdata_q;
    assign o_rsp.ack   = ack_q;
    assign o_rsp.err   = 1'b0;
    assign o_timer_int = flag_q;

endmodule

/* source/boot_mem.sv */
// On-chip boot RAM
`timescale 1ns/1ps

module boot_mem (
    input  logic                i_clk,
    input  logic                i_rst,
    input  wb_pkg::wb_req_t     i_req,
    input  wb_pkg::slave_sel_e  i_sel,
    output wb_pkg::wb_rsp_t     o_rsp
);

    logic [wb_pkg::WB_DWIDTH-1:0]  mem [soc_pkg::BOOT_WORDS];
    logic [soc_pkg::BOOT_ADR_W-1:0] word_adr;
    logic [wb_pkg::WB_DWIDTH-1:0]  rdata_q;
    logic                          ack_q;
    logic                          access;

    // Word address from adr[9:2]
    assign word_adr = i_req.adr[soc_pkg::BOOT_ADR_W+1:2];

    // New access only while the previous ack is not pending
    assign access = i_req.cyc && i_req.stb && (i_sel == wb_pkg::SLV_BOOT) && !ack_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Byte lanes written per sel bit
    always_ff @(posedge i_clk) begin
        if (access && i_req.we) begin
            for (int b = 0; b < wb_pkg::WB_SWIDTH; b++) begin
                if (i_req.sel[b]) begin
                    mem[word_adr][b*8 +: 8] <= i_req.dat[b*8 +: 8];
                end
            end
        end
        if (access) begin
            rdata_q <= mem[word_adr];
        end
    end

    assign o_rsp.dat = rdata_q;
    assign o_rsp.ack = ack_q;
    assign o_rsp.err = 1'b0;

endmodule

/* source/wb_arbiter.sv */
// Two-master Wishbone arbiter
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                i_clk,
    input  logic                i_rst,

    // Master 0, Ethernet DMA position
    input  wb_pkg::wb_req_t     i_m0_req,
    output wb_pkg::wb_rsp_t     o_m0_rsp,

    // Master 1, processor position
    input  wb_pkg::wb_req_t     i_m1_req,
    output wb_pkg::wb_rsp_t     o_m1_rsp,

    // Shared slave side
    output wb_pkg::wb_req_t     o_slv_req,
    output wb_pkg::slave_sel_e  o_slv_sel,
    input  wb_pkg::wb_rsp_t     i_boot_rsp,
    input  wb_pkg::wb_rsp_t     i_timer_rsp,
    input  wb_pkg::wb_rsp_t     i_ic_rsp
);

    wb_pkg::arb_state_e state_q;
    wb_pkg::arb_state_e state_d;
    wb_pkg::wb_rsp_t    slv_rsp;
    logic               err_q;

    // ------------------------------------------------------------------------
    // Grant state machine
    // ------------------------------------------------------------------------

    // Master 0 wins a tie, grant holds until the owner drops cyc
    always_comb begin
        state_d = state_q;
        case (state_q)
            wb_pkg::ARB_IDLE: begin
                if (i_m0_req.cyc) begin
                    state_d = wb_pkg::ARB_M0;
                end else if (i_m1_req.cyc) begin
                    state_d = wb_pkg::ARB_M1;
                end
            end
            wb_pkg::ARB_M0: begin
                if (!i_m0_req.cyc) begin
                    state_d = wb_pkg::ARB_IDLE;
                end
            end
            wb_pkg::ARB_M1: begin
                if (!i_m1_req.cyc) begin
                    state_d = wb_pkg::ARB_IDLE;
                end
            end
            default: state_d = wb_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= wb_pkg::ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------------
    // Request routing and address decode
    // ------------------------------------------------------------------------

    always_comb begin
        case (state_q)
            wb_pkg::ARB_M0: o_slv_req = i_m0_req;
            wb_pkg::ARB_M1: o_slv_req = i_m1_req;
            default:        o_slv_req = '0;
        endcase
    end

    always_comb begin
        case (o_slv_req.adr[31:24])
            wb_pkg::BOOT_BASE:  o_slv_sel = wb_pkg::SLV_BOOT;
            wb_pkg::TIMER_BASE: o_slv_sel = wb_pkg::SLV_TIMER;
            wb_pkg::IC_BASE:    o_slv_sel = wb_pkg::SLV_IC;
            default:            o_slv_sel = wb_pkg::SLV_NONE;
        endcase
    end

    // Unmapped access answers with a one-cycle err pulse
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= o_slv_req.cyc && o_slv_req.stb &&
                     (o_slv_sel == wb_pkg::SLV_NONE) && !err_q;
        end
    end

    // ------------------------------------------------------------------------
    // Response routing
    // ------------------------------------------------------------------------

    always_comb begin
        slv_rsp = '0;
        case (o_slv_sel)
            wb_pkg::SLV_BOOT:  slv_rsp = i_boot_rsp;
            wb_pkg::SLV_TIMER: slv_rsp = i_timer_rsp;
            wb_pkg::SLV_IC:    slv_rsp = i_ic_rsp;
            default:           slv_rsp.err = err_q;
        endcase
    end

    // Only the granted master sees the response
    assign o_m0_rsp = (state_q == wb_pkg::ARB_M0) ? slv_rsp : '0;
    assign o_m1_rsp = (state_q == wb_pkg::ARB_M1) ? slv_rsp : '0;

endmodule

/* source/soc_pkg.sv */
// Peripheral register definitions
package soc_pkg;

    // Boot memory depth in 32-bit words
    localparam int BOOT_WORDS = 256;
    localparam int BOOT_ADR_W = $clog2(BOOT_WORDS);

    localparam int NUM_TIMERS  = 3;
    localparam int NUM_IRQ_SRC = 4;

    // Interrupt source positions
    localparam int IRQ_SRC_SOFT   = 0;
    localparam int IRQ_SRC_TIMER0 = 1;

    // Enable bit in the timer control register
    localparam int TMR_CTRL_EN = 0;

    // Timer registers on adr[3:2], timer number on adr[9:8]
    typedef enum logic [1:0] {
        TMR_LOAD  = 2'd0,
        TMR_VALUE = 2'd1,
        TMR_CTRL  = 2'd2,
        TMR_CLEAR = 2'd3
    } timer_reg_e;

    // Interrupt controller registers on adr[5:2]
    typedef enum logic [3:0] {
        IC_IRQ_STATUS  = 4'h0,
        IC_IRQ_RAW     = 4'h1,
        IC_IRQ_EN_SET  = 4'h2,
        IC_IRQ_EN_CLR  = 4'h3,
        IC_FIRQ_STATUS = 4'h4,
        IC_FIRQ_EN_SET = 4'h6,
        IC_FIRQ_EN_CLR = 4'h7,
        IC_SOFT_SET    = 4'h8,
        IC_SOFT_CLR    = 4'h9
    } ic_reg_e;

endpackage

/* source/wb_pkg.sv */
// Wishbone bus definitions
package wb_pkg;

    // Bus widths, 32-bit data only
    localparam int WB_DWIDTH = 32;
    localparam int WB_SWIDTH = 4;
    localparam int WB_AWIDTH = 32;

    // Master to slave request
    typedef struct packed {
        logic [WB_AWIDTH-1:0] adr;
        logic [WB_SWIDTH-1:0] sel;
        logic                 we;
        logic [WB_DWIDTH-1:0] dat;
        logic                 cyc;
        logic                 stb;
    } wb_req_t;

    // Slave to master response
    typedef struct packed {
        logic [WB_DWIDTH-1:0] dat;
        logic                 ack;
        logic                 err;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        SLV_BOOT,
        SLV_TIMER,
        SLV_IC,
        SLV_NONE
    } slave_sel_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_M0,
        ARB_M1
    } arb_state_e;

    // Address map, compared with adr[31:24]
    localparam logic [7:0] BOOT_BASE  = 8'h00;
    localparam logic [7:0] TIMER_BASE = 8'h13;
    localparam logic [7:0] IC_BASE    = 8'h14;

endpackage
